// ==== mmu_pkg.sv ====
package mmu_pkg;

    // MIPS cause register exception codes
    typedef enum logic [4:0] {
        EXC_NONE = 5'd0,
        EXC_MOD  = 5'd1,   // store to a clean page
        EXC_TLBL = 5'd2,
        EXC_TLBS = 5'd3,
        EXC_ADEL = 5'd4,
        EXC_ADES = 5'd5,
        EXC_OV   = 5'd12
    } exc_code_e;

    typedef enum logic [1:0] {
        TLB_NOP            = 2'd0,
        TLB_WRITE          = 2'd1,
        TLB_INVALIDATE_ALL = 2'd2
    } tlb_op_e;

    typedef enum logic [1:0] {
        ACC_BYTE = 2'd0,
        ACC_HALF = 2'd1,
        ACC_WORD = 2'd2
    } acc_size_e;

    // upper half of a physical address that bypasses the data cache
    localparam logic [15:0] UNCACHED_PAGE = 16'h1faf;

    // one entry maps an even/odd pair of 4 KB pages
    typedef struct packed {
        logic [18:0] vpn2;
        logic [7:0]  asid;
        logic        g;     // global, ignores asid
        logic [19:0] pfn0;
        logic        v0;
        logic        d0;
        logic [19:0] pfn1;
        logic        v1;
        logic        d1;
    } tlb_entry_t;

    typedef struct packed {
        tlb_op_e    op;
        logic [3:0] index;  // wide enough for 16 entries
        tlb_entry_t entry;
    } tlb_cmd_t;

    // merged lookup for one port, page already picked
    typedef struct packed {
        logic        found;
        logic [3:0]  index;
        logic [19:0] pfn;
        logic        v;
        logic        d;
    } tlb_lookup_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] pc;
    } fetch_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] ppc;
        logic        exception;
        exc_code_e   exc_code;
        logic        refill;
    } fetch_res_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] vaddr;
        logic        rd;
        logic        wr;
        acc_size_e   size;
        logic        overflow;   // from the ALU in execute
        logic        prior_exc;  // raised by an earlier stage
        exc_code_e   prior_code;
        logic [31:0] pc;
    } mem_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] paddr;
        logic        uncached;
        logic        cache_valid;
        logic        wr_en;
        logic [3:0]  wstrb;
        logic        exception;
        exc_code_e   exc_code;
        logic        refill;
        logic [31:0] badvaddr;
    } mem_res_t;

endpackage

// ==== tlb_entry.sv ====
module tlb_entry import mmu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  logic        wr_en,
    input  logic        inval,
    input  tlb_entry_t  wr_entry,
    input  logic [18:0] vpn0,      // fetch port
    input  logic [18:0] vpn1,      // data port
    input  logic [7:0]  asid,
    output logic        hit0,
    output logic        hit1,
    output tlb_entry_t  entry
);

    tlb_entry_t entry_q;
    logic       valid_q;
    logic       asid_ok;

    // entry contents, loaded by a write
    always_ff @(posedge clk) begin
        if (wr_en) begin
            entry_q <= wr_entry;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else if (inval) begin
            valid_q <= 1'b0;   // invalidate-all wipes every slice
        end else if (wr_en) begin
            valid_q <= 1'b1;
        end
    end

    // asid match shared by both ports
    assign asid_ok = entry_q.g || (entry_q.asid == asid);

    assign hit0 = valid_q && asid_ok && (entry_q.vpn2 == vpn0);
    assign hit1 = valid_q && asid_ok && (entry_q.vpn2 == vpn1);

    assign entry = entry_q;

endmodule

// ==== tlb_cmd_writer.sv ====
module tlb_cmd_writer import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic                   clk,
    input  logic                   reset,
    input  tlb_cmd_t               tlb_cmd,
    output logic [TLB_ENTRIES-1:0] wr_en,
    output tlb_entry_t             wr_entry,
    output logic                   inval,
    output logic                   tlb_busy
);

    tlb_op_e    op_q;
    logic [3:0] index_q;
    tlb_entry_t entry_q;

    always_ff @(posedge clk) begin
        if (reset) begin
            op_q <= TLB_NOP;
        end else begin
            op_q <= tlb_cmd.op;
        end
    end

    always_ff @(posedge clk) begin
        index_q <= tlb_cmd.index;
        entry_q <= tlb_cmd.entry;
    end

    // one-hot decode of the registered index
    always_comb begin
        wr_en = '0;
        if (op_q == TLB_WRITE) begin
            wr_en = TLB_ENTRIES'(1) << index_q;
        end
    end

    assign wr_entry = entry_q;
    assign inval    = (op_q == TLB_INVALIDATE_ALL);

    // high while the entries change at the next edge
    assign tlb_busy = (op_q != TLB_NOP);

endmodule

// ==== tlb_hit_merge.sv ====
module tlb_hit_merge import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic [TLB_ENTRIES-1:0] hits0,
    input  logic [TLB_ENTRIES-1:0] hits1,
    input  tlb_entry_t             entries [TLB_ENTRIES],
    input  logic                   odd0,     // va bit 12 of the fetch address
    input  logic                   odd1,     // va bit 12 of the data address
    output tlb_lookup_t            lookup0,
    output tlb_lookup_t            lookup1
);

    // lowest hit index wins when several entries overlap
    function automatic tlb_lookup_t merge_port(
        input logic [TLB_ENTRIES-1:0] hits,
        input logic                   odd
    );
        tlb_lookup_t res;
        tlb_entry_t  sel_entry;
        int          sel;
        sel = 0;
        for (int i = TLB_ENTRIES - 1; i >= 0; i--) begin
            if (hits[i]) begin
                sel = i;
            end
        end
        sel_entry = entries[sel];
        res.found = |hits;
        res.index = 4'(sel);
        if (odd) begin
            res.pfn = sel_entry.pfn1;
            res.v   = sel_entry.v1;
            res.d   = sel_entry.d1;
        end else begin
            res.pfn = sel_entry.pfn0;
            res.v   = sel_entry.v0;
            res.d   = sel_entry.d0;
        end
        return res;
    endfunction

    always_comb begin
        lookup0 = merge_port(hits0, odd0);
    end

    always_comb begin
        lookup1 = merge_port(hits1, odd1);
    end

endmodule

// ==== fetch_translate.sv ====
module fetch_translate import mmu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  fetch_req_t  fetch_req,
    input  tlb_lookup_t lookup0,
    input  logic        fetch_stall,
    input  logic        pipe_flush,
    input  logic        tlb_busy,
    output fetch_res_t  fetch_res
);

    logic        mapped;
    logic        adel;
    logic        tlb_exc;
    logic        exc;
    exc_code_e   code;
    logic        refill;
    logic [31:0] ppc;
    logic        valid_d;

    logic        valid_q;
    logic [31:0] ppc_q;
    logic        exc_q;
    exc_code_e   code_q;
    logic        refill_q;

    // kseg0/kseg1 (top bits 10) bypass the TLB
    assign mapped = (fetch_req.pc[31:30] != 2'b10);

    assign adel    = fetch_req.valid && (fetch_req.pc[1:0] != 2'b00);
    assign tlb_exc = mapped && (!lookup0.found || !lookup0.v);  // refill or invalid page
    assign exc     = adel || tlb_exc;
    assign code    = adel ? EXC_ADEL : (tlb_exc ? EXC_TLBL : EXC_NONE);
    assign refill  = mapped && !lookup0.found && !adel;

    always_comb begin
        if (!mapped) begin
            ppc = {3'b000, fetch_req.pc[28:0]};
        end else if (!exc) begin
            ppc = {lookup0.pfn, fetch_req.pc[11:0]};
        end else begin
            ppc = 32'd0;
        end
    end

    assign valid_d = fetch_req.valid && !fetch_stall && !pipe_flush && !tlb_busy && !exc;

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q <= 1'b0;
        end else begin
            valid_q <= valid_d;
        end
    end

    always_ff @(posedge clk) begin
        ppc_q    <= ppc;
        exc_q    <= exc;
        code_q   <= code;
        refill_q <= refill;
    end

    assign fetch_res.valid     = valid_q;
    assign fetch_res.ppc       = ppc_q;
    assign fetch_res.exception = exc_q;
    assign fetch_res.exc_code  = code_q;
    assign fetch_res.refill    = refill_q;

endmodule

// ==== data_translate.sv ====
module data_translate import mmu_pkg::*; (
    input  logic        clk,
    input  logic        reset,
    input  mem_req_t    mem_req,
    input  tlb_lookup_t lookup1,
    input  logic        pipe_flush,
    output mem_res_t    mem_res
);

    logic        mapped;
    logic        access;
    logic        misaligned;
    logic        tlb_bad;     // miss or invalid page
    logic        tlb_mod;
    logic [31:0] paddr;
    logic        uncached;
    logic        exc;
    exc_code_e   code;
    logic        refill;
    logic [31:0] badvaddr;
    logic        wr_en_d;
    logic        cache_valid_d;
    logic [3:0]  wstrb_d;

    logic        valid_q;
    logic        cache_valid_q;
    logic        wr_en_q;
    logic [3:0]  wstrb_q;
    logic [31:0] paddr_q;
    logic        uncached_q;
    logic        exc_q;
    exc_code_e   code_q;
    logic        refill_q;
    logic [31:0] badvaddr_q;

    assign mapped = (mem_req.vaddr[31:30] != 2'b10);
    assign access = mem_req.rd || mem_req.wr;

    assign misaligned = (mem_req.size == ACC_HALF && mem_req.vaddr[0]) ||
                        (mem_req.size == ACC_WORD && mem_req.vaddr[1:0] != 2'b00);

    assign tlb_bad = mapped && access && (!lookup1.found || !lookup1.v);
    assign tlb_mod = mapped && mem_req.wr && lookup1.found && lookup1.v && !lookup1.d;

    assign paddr    = mapped ? {lookup1.pfn, mem_req.vaddr[11:0]}
                             : {3'b000, mem_req.vaddr[28:0]};
    assign uncached = (paddr[31:16] == UNCACHED_PAGE);

    // earlier stages first, then overflow, alignment, tlb
    always_comb begin
        exc      = 1'b1;
        refill   = 1'b0;
        code     = EXC_NONE;
        badvaddr = mem_req.vaddr;
        if (mem_req.prior_exc) begin
            code     = mem_req.prior_code;
            badvaddr = mem_req.pc;
        end else if (mem_req.overflow) begin
            code     = EXC_OV;
            badvaddr = 32'd0;
        end else if (mem_req.wr && misaligned) begin
            code = EXC_ADES;
        end else if (mem_req.rd && misaligned) begin
            code = EXC_ADEL;
        end else if (tlb_bad) begin
            code   = mem_req.wr ? EXC_TLBS : EXC_TLBL;
            refill = !lookup1.found;
        end else if (tlb_mod) begin
            code = EXC_MOD;
        end else begin
            exc      = 1'b0;
            badvaddr = mem_req.pc;
        end
    end

    assign wr_en_d       = mem_req.valid && mem_req.wr && !exc && !pipe_flush;
    assign cache_valid_d = mem_req.valid && !uncached && !exc && !pipe_flush;

    always_comb begin
        wstrb_d = 4'b0000;
        if (wr_en_d) begin
            case (mem_req.size)
                ACC_BYTE: wstrb_d = 4'b0001 << paddr[1:0];
                ACC_HALF: wstrb_d = paddr[1] ? 4'b1100 : 4'b0011;
                default:  wstrb_d = 4'b1111;   // sw
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            valid_q       <= 1'b0;
            cache_valid_q <= 1'b0;
            wr_en_q       <= 1'b0;
            wstrb_q       <= 4'b0000;
        end else begin
            valid_q       <= mem_req.valid;
            cache_valid_q <= cache_valid_d;
            wr_en_q       <= wr_en_d;
            wstrb_q       <= wstrb_d;
        end
    end

    always_ff @(posedge clk) begin
        paddr_q    <= paddr;
        uncached_q <= uncached;
        exc_q      <= exc;
        code_q     <= code;
        refill_q   <= refill;
        badvaddr_q <= badvaddr;
    end

    assign mem_res.valid       = valid_q;
    assign mem_res.paddr       = paddr_q;
    assign mem_res.uncached    = uncached_q;
    assign mem_res.cache_valid = cache_valid_q;
    assign mem_res.wr_en       = wr_en_q;
    assign mem_res.wstrb       = wstrb_q;
    assign mem_res.exception   = exc_q;
    assign mem_res.exc_code    = code_q;
    assign mem_res.refill      = refill_q;
    assign mem_res.badvaddr    = badvaddr_q;

endmodule

// ==== mmu_top.sv ====
module mmu_top import mmu_pkg::*; #(
    parameter int TLB_ENTRIES = 16
) (
    input  logic       clk,
    input  logic       reset,
    input  logic [7:0] asid,
    input  tlb_cmd_t   tlb_cmd,
    input  logic       pipe_flush,
    input  logic       fetch_stall,
    input  fetch_req_t fetch_req,
    output fetch_res_t fetch_res,
    input  mem_req_t   mem_req,
    output mem_res_t   mem_res
);

    logic [TLB_ENTRIES-1:0] wr_en;
    tlb_entry_t             wr_entry;
    logic                   inval;
    logic                   tlb_busy;
    logic [TLB_ENTRIES-1:0] hit0;
    logic [TLB_ENTRIES-1:0] hit1;
    tlb_entry_t             entries [TLB_ENTRIES];
    tlb_lookup_t            lookup0;
    tlb_lookup_t            lookup1;

    tlb_cmd_writer #(.TLB_ENTRIES(TLB_ENTRIES)) u_writer (
        .clk, .reset, .tlb_cmd, .wr_en, .wr_entry, .inval, .tlb_busy
    );

    for (genvar i = 0; i < TLB_ENTRIES; i++) begin : g_entry
        tlb_entry u_entry (
            .clk      (clk),
            .reset    (reset),
            .wr_en    (wr_en[i]),
            .inval    (inval),
            .wr_entry (wr_entry),
            .vpn0     (fetch_req.pc[31:13]),
            .vpn1     (mem_req.vaddr[31:13]),
            .asid     (asid),
            .hit0     (hit0[i]),
            .hit1     (hit1[i]),
            .entry    (entries[i])
        );
    end

    tlb_hit_merge #(.TLB_ENTRIES(TLB_ENTRIES)) u_merge (
        .hits0   (hit0),
        .hits1   (hit1),
        .entries (entries),
        .odd0    (fetch_req.pc[12]),     // even/odd page select
        .odd1    (mem_req.vaddr[12]),
        .lookup0 (lookup0),
        .lookup1 (lookup1)
    );

    fetch_translate u_fetch (
        .clk, .reset, .fetch_req, .lookup0, .fetch_stall, .pipe_flush, .tlb_busy, .fetch_res
    );

    data_translate u_data (
        .clk, .reset, .mem_req, .lookup1, .pipe_flush, .mem_res
    );

endmodule

// ==== tb_mmu.sv ====
module tb_mmu import mmu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam logic [31:0] REQ_PC = 32'h0040_0100;   // pc carried by every data request
    localparam fetch_req_t  FETCH_IDLE = '0;
    localparam mem_req_t    MEM_IDLE = '0;
    localparam tlb_cmd_t    CMD_IDLE = '0;
    localparam logic [3:0]  BYTE_STRB [4] = '{4'h1, 4'h2, 4'h4, 4'h8};

    logic        clk;
    logic        reset;
    logic [7:0]  asid;
    tlb_cmd_t    tlb_cmd;
    logic        pipe_flush;
    logic        fetch_stall;
    fetch_req_t  fetch_req;
    fetch_res_t  fetch_res;
    mem_req_t    mem_req;
    mem_res_t    mem_res;

    logic [31:0] lcg_state = 32'd48131;
    tlb_entry_t  shadow [4];   // entries written by the mapped test

    mmu_top #(.TLB_ENTRIES(16)) UUT (
        .clk, .reset, .asid, .tlb_cmd, .pipe_flush, .fetch_stall,
        .fetch_req, .fetch_res, .mem_req, .mem_res
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
        return lcg_state;
    endfunction

    function automatic fetch_req_t fetch_at(input logic [31:0] pc);
        fetch_req_t f;
        f.valid = 1'b1;
        f.pc    = pc;
        return f;
    endfunction

    function automatic mem_req_t mem_at(input logic [31:0] va, input logic wr,
                                        input acc_size_e sz);
        mem_req_t m;
        m            = '0;
        m.valid      = 1'b1;
        m.vaddr      = va;
        m.rd         = !wr;
        m.wr         = wr;
        m.size       = sz;
        m.prior_code = EXC_NONE;
        m.pc         = REQ_PC;
        return m;
    endfunction

    function automatic fetch_res_t fetch_ok(input logic [31:0] pa);
        fetch_res_t r;
        r.valid     = 1'b1;
        r.ppc       = pa;
        r.exception = 1'b0;
        r.exc_code  = EXC_NONE;
        r.refill    = 1'b0;
        return r;
    endfunction

    function automatic fetch_res_t fetch_fault(input logic [31:0] pa, input exc_code_e code,
                                               input logic refill);
        fetch_res_t r;
        r.valid     = 1'b0;
        r.ppc       = pa;
        r.exception = 1'b1;
        r.exc_code  = code;
        r.refill    = refill;
        return r;
    endfunction

    function automatic mem_res_t mem_ok(input logic [31:0] pa, input logic wr,
                                        input logic [3:0] strb);
        mem_res_t r;
        r.valid       = 1'b1;
        r.paddr       = pa;
        r.uncached    = (pa[31:16] == UNCACHED_PAGE);
        r.cache_valid = !r.uncached;
        r.wr_en       = wr;
        r.wstrb       = strb;
        r.exception   = 1'b0;
        r.exc_code    = EXC_NONE;
        r.refill      = 1'b0;
        r.badvaddr    = REQ_PC;
        return r;
    endfunction

    // paddr and uncached are not compared for a faulting access
    function automatic mem_res_t mem_fault(input exc_code_e code, input logic refill,
                                           input logic [31:0] bad);
        mem_res_t r;
        r           = '0;
        r.valid     = 1'b1;
        r.exception = 1'b1;
        r.exc_code  = code;
        r.refill    = refill;
        r.badvaddr  = bad;
        return r;
    endfunction

    task automatic report_mismatch(input string tag, input string field,
                                   input logic [31:0] got, input logic [31:0] exp);
        $display("CHECK FAILED %s in %s: got %h expected %h", field, tag, got, exp);
        $display("** FAIL **");
        $fatal(1, "stopped at first mismatch");
    endtask

    task automatic check_fetch(input string tag, input fetch_res_t exp);
        fetch_res_t got;
        got = fetch_res;
        if (got.valid !== exp.valid)
            report_mismatch(tag, "fetch_res.valid", 32'(got.valid), 32'(exp.valid));
        if (got.ppc !== exp.ppc)
            report_mismatch(tag, "fetch_res.ppc", got.ppc, exp.ppc);
        if (got.exception !== exp.exception)
            report_mismatch(tag, "fetch_res.exception", 32'(got.exception), 32'(exp.exception));
        if (got.exc_code !== exp.exc_code)
            report_mismatch(tag, "fetch_res.exc_code", 32'(got.exc_code), 32'(exp.exc_code));
        if (got.refill !== exp.refill)
            report_mismatch(tag, "fetch_res.refill", 32'(got.refill), 32'(exp.refill));
    endtask

    task automatic check_mem(input string tag, input mem_res_t exp);
        mem_res_t got;
        got = mem_res;
        if (got.valid !== exp.valid)
            report_mismatch(tag, "mem_res.valid", 32'(got.valid), 32'(exp.valid));
        if (!exp.exception && got.paddr !== exp.paddr)
            report_mismatch(tag, "mem_res.paddr", got.paddr, exp.paddr);
        if (!exp.exception && got.uncached !== exp.uncached)
            report_mismatch(tag, "mem_res.uncached", 32'(got.uncached), 32'(exp.uncached));
        if (got.cache_valid !== exp.cache_valid)
            report_mismatch(tag, "mem_res.cache_valid", 32'(got.cache_valid),
                            32'(exp.cache_valid));
        if (got.wr_en !== exp.wr_en)
            report_mismatch(tag, "mem_res.wr_en", 32'(got.wr_en), 32'(exp.wr_en));
        if (got.wstrb !== exp.wstrb)
            report_mismatch(tag, "mem_res.wstrb", 32'(got.wstrb), 32'(exp.wstrb));
        if (got.exception !== exp.exception)
            report_mismatch(tag, "mem_res.exception", 32'(got.exception), 32'(exp.exception));
        if (got.exc_code !== exp.exc_code)
            report_mismatch(tag, "mem_res.exc_code", 32'(got.exc_code), 32'(exp.exc_code));
        if (got.refill !== exp.refill)
            report_mismatch(tag, "mem_res.refill", 32'(got.refill), 32'(exp.refill));
        if (got.badvaddr !== exp.badvaddr)
            report_mismatch(tag, "mem_res.badvaddr", got.badvaddr, exp.badvaddr);
    endtask

    // one request per port, sampled at the negedge after capture
    task automatic issue(input fetch_req_t f, input mem_req_t m);
        @(posedge clk);
        fetch_req <= f;
        mem_req   <= m;
        @(posedge clk);
        fetch_req <= FETCH_IDLE;
        mem_req   <= MEM_IDLE;
        @(negedge clk);
    endtask

    task automatic set_levels(input logic flush, input logic stall);
        @(posedge clk);
        pipe_flush  <= flush;
        fetch_stall <= stall;
    endtask

    task automatic set_asid(input logic [7:0] a);
        @(posedge clk);
        asid <= a;
    endtask

    task automatic send_cmd(input tlb_op_e op, input logic [3:0] idx, input tlb_entry_t e);
        tlb_cmd_t c;
        c.op    = op;
        c.index = idx;
        c.entry = e;
        @(posedge clk);
        tlb_cmd <= c;
        @(posedge clk);
        tlb_cmd <= CMD_IDLE;
    endtask

    task automatic wait_tlb_idle();
        int n;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 20) begin
                $display("timeout: the TLB stayed busy after a command");
                $display("** FAIL **");
                $fatal(1, "tlb_busy never dropped");
            end
        end while (UUT.tlb_busy);
    endtask

    task automatic unmapped_test();
        issue(fetch_at(32'h8000_1234), mem_at(32'h9FAF_0040, 1'b0, ACC_WORD));
        check_fetch("kseg0 fetch", fetch_ok(32'h0000_1234));
        check_mem("uncached kseg0 load", mem_ok(32'h1FAF_0040, 1'b0, 4'h0));
        issue(fetch_at(32'hA040_0010), mem_at(32'hA000_0100, 1'b0, ACC_WORD));
        check_fetch("kseg1 fetch", fetch_ok(32'h0040_0010));
        check_mem("kseg1 load", mem_ok(32'h0000_0100, 1'b0, 4'h0));
    endtask

    task automatic mapped_test();
        logic [31:0] r;
        logic [31:0] va;
        logic [31:0] pa;
        logic        odd_page;
        tlb_entry_t  e;
        for (int i = 0; i < 4; i++) begin
            r      = lcg_next();
            e.vpn2 = {2'b00, r[12:0], 4'(i)};   // distinct kuseg pairs
            e.asid = 8'h11;
            e.g    = (i == 0);
            r      = lcg_next();
            e.pfn0 = {4'h0, r[15:0]};   // never in the uncached page
            e.pfn1 = {4'h0, r[31:16]};
            e.v0   = 1'b1;
            e.d0   = 1'b1;
            e.v1   = 1'b1;
            e.d1   = 1'b1;
            shadow[i] = e;
            send_cmd(TLB_WRITE, 4'(i), e);
            wait_tlb_idle();
        end
        for (int i = 0; i < 4; i++) begin
            for (int j = 0; j < 2; j++) begin
                odd_page = j[0];
                r  = lcg_next();
                va = {shadow[i].vpn2, odd_page, r[11:2], 2'b00};
                pa = {odd_page ? shadow[i].pfn1 : shadow[i].pfn0, va[11:0]};
                issue(fetch_at(va), mem_at(va, 1'b0, ACC_WORD));
                check_fetch("mapped fetch", fetch_ok(pa));
                check_mem("mapped load", mem_ok(pa, 1'b0, 4'h0));
            end
        end
        set_asid(8'h22);
        va = {shadow[0].vpn2, 13'h0080};
        issue(fetch_at(va), mem_at(va, 1'b0, ACC_WORD));
        check_fetch("global fetch, other asid", fetch_ok({shadow[0].pfn0, 12'h080}));
        check_mem("global load, other asid", mem_ok({shadow[0].pfn0, 12'h080}, 1'b0, 4'h0));
        va = {shadow[1].vpn2, 13'h0080};
        issue(fetch_at(va), mem_at(va, 1'b0, ACC_WORD));
        check_fetch("private fetch, other asid", fetch_fault(32'h0, EXC_TLBL, 1'b1));
        check_mem("private load, other asid", mem_fault(EXC_TLBL, 1'b1, va));
        set_asid(8'h11);
    endtask

    task automatic fault_test();
        tlb_entry_t  e;
        logic [31:0] even_va;
        logic [31:0] odd_va;
        logic [31:0] miss_va;
        e       = '0;
        e.vpn2  = 19'h2_0123;
        e.asid  = 8'h11;
        e.pfn0  = 20'h00abc;   // even page invalid
        e.pfn1  = 20'h00def;
        e.v1    = 1'b1;        // odd page valid but clean
        even_va = {e.vpn2, 13'h0040};
        odd_va  = {e.vpn2, 13'h1040};
        miss_va = 32'hE000_1000;
        send_cmd(TLB_WRITE, 4'd4, e);
        wait_tlb_idle();
        issue(fetch_at(even_va), mem_at(even_va, 1'b0, ACC_WORD));
        check_fetch("invalid page fetch", fetch_fault(32'h0, EXC_TLBL, 1'b0));
        check_mem("invalid page load", mem_fault(EXC_TLBL, 1'b0, even_va));
        issue(FETCH_IDLE, mem_at(even_va, 1'b1, ACC_WORD));
        check_mem("invalid page store", mem_fault(EXC_TLBS, 1'b0, even_va));
        issue(FETCH_IDLE, mem_at(odd_va, 1'b1, ACC_WORD));
        check_mem("clean page store", mem_fault(EXC_MOD, 1'b0, odd_va));
        issue(FETCH_IDLE, mem_at(odd_va, 1'b0, ACC_WORD));
        check_mem("clean page load", mem_ok({e.pfn1, 12'h040}, 1'b0, 4'h0));
        issue(fetch_at(miss_va), mem_at(miss_va, 1'b1, ACC_WORD));
        check_fetch("miss fetch", fetch_fault(32'h0, EXC_TLBL, 1'b1));
        check_mem("miss store", mem_fault(EXC_TLBS, 1'b1, miss_va));
    endtask

    task automatic align_test();
        mem_req_t m;
        issue(fetch_at(32'h8000_0102), MEM_IDLE);
        check_fetch("misaligned kseg0 pc", fetch_fault(32'h0000_0102, EXC_ADEL, 1'b0));
        issue(fetch_at(32'hE000_0002), mem_at(32'h8000_0001, 1'b0, ACC_HALF));
        check_fetch("misaligned mapped pc", fetch_fault(32'h0, EXC_ADEL, 1'b0));
        check_mem("misaligned lh", mem_fault(EXC_ADEL, 1'b0, 32'h8000_0001));
        issue(FETCH_IDLE, mem_at(32'h8000_0002, 1'b0, ACC_WORD));
        check_mem("misaligned lw", mem_fault(EXC_ADEL, 1'b0, 32'h8000_0002));
        issue(FETCH_IDLE, mem_at(32'h8000_0003, 1'b1, ACC_HALF));
        check_mem("misaligned sh", mem_fault(EXC_ADES, 1'b0, 32'h8000_0003));
        issue(FETCH_IDLE, mem_at(32'h8000_0006, 1'b1, ACC_WORD));
        check_mem("misaligned sw", mem_fault(EXC_ADES, 1'b0, 32'h8000_0006));
        m = mem_at(32'h8000_0003, 1'b1, ACC_WORD);
        m.overflow = 1'b1;     // beats the alignment fault
        issue(FETCH_IDLE, m);
        check_mem("overflow", mem_fault(EXC_OV, 1'b0, 32'h0));
        m.prior_exc  = 1'b1;
        m.prior_code = EXC_TLBL;
        issue(FETCH_IDLE, m);
        check_mem("prior exception", mem_fault(EXC_TLBL, 1'b0, REQ_PC));
    endtask

    task automatic strobe_test();
        logic [31:0] va;
        for (int k = 0; k < 4; k++) begin
            va = 32'h8000_0200 + 32'(k);
            issue(FETCH_IDLE, mem_at(va, 1'b1, ACC_BYTE));
            check_mem("sb", mem_ok({3'b000, va[28:0]}, 1'b1, BYTE_STRB[k]));
            issue(FETCH_IDLE, mem_at(va, 1'b0, ACC_BYTE));
            check_mem("lb", mem_ok({3'b000, va[28:0]}, 1'b0, 4'h0));
        end
        for (int k = 0; k < 4; k += 2) begin
            va = 32'h8000_0200 + 32'(k);
            issue(FETCH_IDLE, mem_at(va, 1'b1, ACC_HALF));
            check_mem("sh", mem_ok({3'b000, va[28:0]}, 1'b1, (k == 0) ? 4'h3 : 4'hc));
        end
        issue(FETCH_IDLE, mem_at(32'h8000_0200, 1'b1, ACC_WORD));
        check_mem("sw", mem_ok(32'h0000_0200, 1'b1, 4'hf));
        issue(FETCH_IDLE, mem_at(32'hBFAF_0010, 1'b1, ACC_WORD));
        check_mem("uncached sw", mem_ok(32'h1FAF_0010, 1'b1, 4'hf));
    endtask

    task automatic control_test();
        fetch_res_t  fe;
        mem_res_t    me;
        tlb_entry_t  e;
        logic [31:0] va;
        fe       = fetch_ok(32'h0000_0400);
        fe.valid = 1'b0;
        set_levels(1'b0, 1'b1);
        issue(fetch_at(32'h8000_0400), MEM_IDLE);
        check_fetch("stalled fetch", fe);
        set_levels(1'b1, 1'b0);
        issue(fetch_at(32'h8000_0400), mem_at(32'h8000_0200, 1'b1, ACC_WORD));
        me             = mem_ok(32'h0000_0200, 1'b1, 4'hf);
        me.cache_valid = 1'b0;
        me.wr_en       = 1'b0;
        me.wstrb       = 4'h0;
        check_fetch("flushed fetch", fe);
        check_mem("flushed store", me);
        set_levels(1'b0, 1'b0);

        // fetch presented while the write is being applied
        e      = '0;
        e.vpn2 = 19'h3_0000;
        e.g    = 1'b1;
        e.pfn0 = 20'h01234;
        e.v0   = 1'b1;
        e.d0   = 1'b1;
        send_cmd(TLB_WRITE, 4'd15, e);
        fetch_req <= fetch_at(32'h8000_0400);
        @(posedge clk);
        fetch_req <= FETCH_IDLE;
        @(negedge clk);
        check_fetch("fetch in busy cycle", fe);
        wait_tlb_idle();
        issue(fetch_at(32'h6000_0010), MEM_IDLE);
        check_fetch("fetch after write", fetch_ok(32'h0123_4010));

        send_cmd(TLB_INVALIDATE_ALL, 4'd0, '0);
        wait_tlb_idle();
        for (int i = 0; i < 4; i++) begin
            va = {shadow[i].vpn2, 13'h0010};
            issue(fetch_at(va), mem_at(va, 1'b0, ACC_WORD));
            check_fetch("fetch after invalidate", fetch_fault(32'h0, EXC_TLBL, 1'b1));
            check_mem("load after invalidate", mem_fault(EXC_TLBL, 1'b1, va));
        end
    endtask

    initial begin
        reset       <= 1'b1;
        asid        <= 8'h11;
        tlb_cmd     <= CMD_IDLE;
        pipe_flush  <= 1'b0;
        fetch_stall <= 1'b0;
        fetch_req   <= FETCH_IDLE;
        mem_req     <= MEM_IDLE;
        repeat (4) @(posedge clk);
        reset <= 1'b0;
        unmapped_test();
        mapped_test();
        fault_test();
        align_test();
        strobe_test();
        control_test();
        $display("** PASS **");
        $finish;
    end

endmodule

// ==== compile.f ====
mmu_pkg.sv
tlb_entry.sv
tlb_cmd_writer.sv
tlb_hit_merge.sv
fetch_translate.sv
data_translate.sv
mmu_top.sv
tb_mmu.sv

// ==== run_sim.sh ====
#!/bin/sh
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --top-module tb_mmu -f compile.f -o tb_mmu_sim > build.log 2>&1
build_status=$?
if [ $build_status -ne 0 ]; then
    cat build.log
    echo "build failed with status $build_status"
    exit 1
fi

./obj_dir/tb_mmu_sim > sim.log 2>&1
sim_status=$?
cat sim.log

if grep -q -F "** PASS **" sim.log; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed with status $sim_status"
    exit 1
fi
